// File: rtl/exec_pkg.sv
// Shared types for the execute stage: instruction views, opcodes, ALU classes and codes.
package exec_pkg;

    parameter int XLEN_DEFAULT = 64; // Data path width.

    typedef enum logic [6:0] {
        OPC_LOAD      = 7'b0000011, OPC_STORE     = 7'b0100011,
        OPC_BRANCH    = 7'b1100011, OPC_OP_IMM    = 7'b0010011,
        OPC_OP        = 7'b0110011, OPC_OP_IMM_32 = 7'b0011011,
        OPC_OP_32     = 7'b0111011, OPC_SYSTEM    = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        CLS_ADD   = 3'b000, // Loads and stores.
        CLS_SUB   = 3'b001, // Branch compare.
        CLS_INT   = 3'b010,
        CLS_INT_W = 3'b011,
        CLS_CSR   = 3'b100,
        CLS_NONE  = 3'b111  // Unsupported opcode.
    } alu_class_e;

    typedef enum logic [4:0] {
        ALU_ADD   = 5'b00000, ALU_SUB   = 5'b00001, ALU_AND   = 5'b00010, ALU_OR    = 5'b00011,
        ALU_XOR   = 5'b00100, ALU_SLL   = 5'b00101, ALU_SLT   = 5'b00110, ALU_SLTU  = 5'b00111,
        ALU_SRL   = 5'b01000, ALU_SRA   = 5'b01001, ALU_ADDW  = 5'b01010, ALU_SUBW  = 5'b01011,
        ALU_SLLW  = 5'b01100, ALU_SRLW  = 5'b01101, ALU_SRAW  = 5'b01110, ALU_ADDIW = 5'b01111,
        ALU_CSRRW = 5'b10000, ALU_CSRRS = 5'b10001, ALU_CSRRC = 5'b10010, ALU_DIVW  = 5'b10011,
        ALU_MULW  = 5'b10100, ALU_DIVU  = 5'b10101, ALU_DIVUW = 5'b10110, ALU_REMU  = 5'b10111,
        ALU_REMUW = 5'b11000, ALU_REMW  = 5'b11001, ALU_REM   = 5'b11010, ALU_MUL   = 5'b11011
    } alu_ctrl_e;

    typedef enum logic [1:0] {
        IMM_I = 2'b00,
        IMM_S = 2'b01,
        IMM_Z = 2'b10  // CSR zimm in the rs1 field.
    } imm_fmt_e;

    // ------------------------------------------------------------------------
    // One instruction word, three ways to look at it.
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fields_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fields_t;

    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
        s_fields_t s_fields;
    } instr_t;

endpackage

// File: rtl/exec_ctrl_if.sv
// Decoded control bundle from the pipeline control to the combinational datapath blocks.
`timescale 1ns/100ps

interface exec_ctrl_if #(
    parameter int XLEN = 64
);
    import exec_pkg::*;

    instr_t            instr;     // Stage 1 instruction word.
    alu_class_e        alu_class;
    logic              use_imm;   // Operand B from immediate.
    imm_fmt_e          imm_fmt;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   csr_data;  // Old CSR value.

    alu_ctrl_e         alu_ctrl;  // From the ALU decoder.
    logic              illegal;
    logic [XLEN-1:0]   imm;       // From the immediate generator.

    modport ctrl (
        output instr, alu_class, use_imm, imm_fmt, rs1_data, rs2_data, csr_data
    );

    modport dp (
        input  instr, alu_class, use_imm, imm_fmt, rs1_data, rs2_data, csr_data,
        output alu_ctrl, illegal, imm
    );

endinterface

// File: rtl/exec_control.sv
// Opcode decode and the two-stage valid/ready pipeline around the execute datapath.
`timescale 1ns/100ps

module exec_control #(
    parameter int XLEN = 64
) (
    input  logic              i_clk,
    input  logic              i_rst_n,

    // Input side.
    input  logic              i_valid,
    output logic              o_ready,
    input  exec_pkg::instr_t  i_instr,
    input  logic [XLEN-1:0]   i_rs1_data,
    input  logic [XLEN-1:0]   i_rs2_data,
    input  logic [XLEN-1:0]   i_csr_data,

    // Datapath return.
    input  logic [XLEN-1:0]   i_result,
    input  logic              i_illegal,

    // Output side.
    output logic              o_valid,
    input  logic              i_ready,
    output logic [XLEN-1:0]   o_result,
    output logic              o_illegal,

    exec_ctrl_if.ctrl         ctrl
);
    import exec_pkg::*;

    logic            s1_valid;
    logic            s2_valid;
    logic            s1_load;   // Stage 1 may take a new item.
    logic            s2_load;   // Stage 2 may take a new item.
    logic            in_fire;
    alu_class_e      dec_class;
    logic            dec_use_imm;
    imm_fmt_e        dec_fmt;
    logic [XLEN-1:0] s2_result;
    logic            s2_illegal;

    // ------------------------------------------------------------------------
    // Major opcode decode.
    // ------------------------------------------------------------------------
    always_comb begin
        dec_class   = CLS_NONE;
        dec_use_imm = 1'b0;
        dec_fmt     = IMM_I;
        case (i_instr.r_fields.opcode)
            OPC_LOAD: begin
                dec_class   = CLS_ADD;
                dec_use_imm = 1'b1;
            end
            OPC_STORE: begin
                dec_class   = CLS_ADD;
                dec_use_imm = 1'b1;
                dec_fmt     = IMM_S;
            end
            OPC_BRANCH:    dec_class = CLS_SUB;
            OPC_OP_IMM: begin
                dec_class   = CLS_INT;
                dec_use_imm = 1'b1;
            end
            OPC_OP:        dec_class = CLS_INT;
            OPC_OP_IMM_32: begin
                dec_class   = CLS_INT_W;
                dec_use_imm = 1'b1;
            end
            OPC_OP_32:     dec_class = CLS_INT_W;
            OPC_SYSTEM: begin
                dec_class = CLS_CSR;
                if (i_instr.i_fields.funct3[2]) dec_fmt = IMM_Z; // CSRxxI forms.
            end
            default: ;
        endcase
    end

    // ------------------------------------------------------------------------
    // Pipeline control.
    // ------------------------------------------------------------------------
    assign s2_load = ~s2_valid | i_ready;
    assign s1_load = ~s1_valid | s2_load;
    assign o_ready = s1_load;
    assign in_fire = i_valid & s1_load;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (s1_load) s1_valid <= i_valid;
            if (s2_load) s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (in_fire) begin
            ctrl.instr     <= i_instr;
            ctrl.alu_class <= dec_class;
            ctrl.use_imm   <= dec_use_imm;
            ctrl.imm_fmt   <= dec_fmt;
            ctrl.rs1_data  <= i_rs1_data;
            ctrl.rs2_data  <= i_rs2_data;
            ctrl.csr_data  <= i_csr_data;
        end
        if (s2_load & s1_valid) begin
            s2_result  <= i_result;
            s2_illegal <= i_illegal;
        end
    end

    assign o_valid   = s2_valid;
    assign o_result  = s2_result;
    assign o_illegal = s2_illegal;

endmodule

// File: rtl/alu_decoder.sv
// Refines the ALU class and function bits of the stage 1 instruction into an ALU control code.
`timescale 1ns/100ps

module alu_decoder (
    exec_ctrl_if.dp dp
);
    import exec_pkg::*;

    logic       op_5;
    logic [2:0] funct3;
    logic       f7_5;
    logic       f7_0;
    logic [1:0] op_f7;

    assign op_5   = dp.instr.r_fields.opcode[5];      // Set for register-register forms.
    assign funct3 = dp.instr.r_fields.funct3;
    assign f7_5   = dp.instr.r_fields.funct7[5];
    assign f7_0   = dp.instr.r_fields.funct7[0];      // M extension select.
    assign op_f7  = {op_5, f7_5};

    always_comb begin
        dp.alu_ctrl = ALU_ADD;
        dp.illegal  = 1'b0;

        case (dp.alu_class)
            CLS_ADD: dp.alu_ctrl = ALU_ADD;         // Address add.
            CLS_SUB: dp.alu_ctrl = ALU_SUB;         // Branch compare.

            // ----------------------------------------------------------------
            // Integer, register and immediate.
            // ----------------------------------------------------------------
            CLS_INT:
                case (funct3)
                    3'b000:
                        if (op_5 & f7_0)          dp.alu_ctrl = ALU_MUL;
                        else if (op_f7 == 2'b11)  dp.alu_ctrl = ALU_SUB;
                        else                      dp.alu_ctrl = ALU_ADD;
                    3'b001: dp.alu_ctrl = ALU_SLL;
                    3'b010: dp.alu_ctrl = ALU_SLT;
                    3'b011: dp.alu_ctrl = ALU_SLTU;
                    3'b100: dp.alu_ctrl = ALU_XOR;
                    3'b101:
                        if (op_5 & f7_0)          dp.alu_ctrl = ALU_DIVU;
                        else if (f7_5)            dp.alu_ctrl = ALU_SRA;
                        else                      dp.alu_ctrl = ALU_SRL;
                    3'b110:
                        if (op_5 & f7_0)          dp.alu_ctrl = ALU_REM;
                        else                      dp.alu_ctrl = ALU_OR;
                    default:
                        if (op_5 & f7_0)          dp.alu_ctrl = ALU_REMU;
                        else                      dp.alu_ctrl = ALU_AND;
                endcase

            // ----------------------------------------------------------------
            // 32-bit word forms.
            // ----------------------------------------------------------------
            CLS_INT_W:
                case (funct3)
                    3'b000:
                        if (f7_0) begin
                            if (op_5) dp.alu_ctrl = ALU_MULW;
                            else      dp.alu_ctrl = ALU_ADDIW;
                        end else begin
                            case (op_f7)
                                2'b11:   dp.alu_ctrl = ALU_SUBW;
                                2'b10:   dp.alu_ctrl = ALU_ADDW;
                                default: dp.alu_ctrl = ALU_ADDIW;
                            endcase
                        end
                    3'b001: dp.alu_ctrl = ALU_SLLW;
                    3'b101:
                        if (f7_0)      dp.alu_ctrl = ALU_DIVUW;
                        else if (f7_5) dp.alu_ctrl = ALU_SRAW;
                        else           dp.alu_ctrl = ALU_SRLW;
                    3'b100: dp.alu_ctrl = ALU_DIVW;
                    3'b110: dp.alu_ctrl = ALU_REMW;
                    3'b111: dp.alu_ctrl = ALU_REMUW;
                    default: dp.illegal = 1'b1;   // No W op at 010 or 011.
                endcase

            CLS_CSR:
                case (funct3[1:0])
                    2'b01:   dp.alu_ctrl = ALU_CSRRW;
                    2'b10:   dp.alu_ctrl = ALU_CSRRS;
                    2'b11:   dp.alu_ctrl = ALU_CSRRC;
                    default: dp.illegal  = 1'b1;  // ECALL, EBREAK and friends.
                endcase

            default: dp.illegal = 1'b1;
        endcase
    end

endmodule

// File: rtl/imm_gen.sv
// Builds the immediate operand from the stage 1 instruction word.
`timescale 1ns/100ps

module imm_gen #(
    parameter int XLEN = 64
) (
    exec_ctrl_if.dp dp
);
    import exec_pkg::*;

    logic [11:0] imm_i;
    logic [11:0] imm_s;
    logic [4:0]  zimm;

    assign imm_i = dp.instr.i_fields.imm12;
    assign imm_s = {dp.instr.s_fields.imm_hi, dp.instr.s_fields.imm_lo}; // Split store field.
    assign zimm  = dp.instr.i_fields.rs1;                                 // CSR immediate.

    always_comb begin
        case (dp.imm_fmt)
            IMM_I:   dp.imm = {{(XLEN-12){imm_i[11]}}, imm_i};
            IMM_S:   dp.imm = {{(XLEN-12){imm_s[11]}}, imm_s};
            IMM_Z:   dp.imm = {{(XLEN-5){1'b0}}, zimm};   // Zero extended.
            default: dp.imm = '0;
        endcase
    end

endmodule

// File: rtl/alu.sv
// Integer, M extension, word and CSR arithmetic for one stage 1 item.
`timescale 1ns/100ps

module alu #(
    parameter int XLEN = 64
) (
    exec_ctrl_if.dp         dp,
    output logic [XLEN-1:0] o_result
);
    import exec_pkg::*;

    localparam int SHW = $clog2(XLEN);

    logic [XLEN-1:0]        a;
    logic [XLEN-1:0]        b;
    logic signed [XLEN-1:0] a_s;
    logic signed [XLEN-1:0] b_s;
    logic [31:0]            a_w;
    logic [31:0]            b_w;
    logic signed [31:0]     a_sw;
    logic signed [31:0]     b_sw;
    logic                   div_zero;
    logic                   div_zero_w;
    logic                   ovf;      // Most negative divided by minus one.
    logic                   ovf_w;
    logic [XLEN-1:0]        res;

    // Sign extends a 32-bit word result to the full width.
    function automatic logic [XLEN-1:0] sext_w(input logic [31:0] v);
        logic signed [XLEN-1:0] r;
        r = $signed(v);
        return r;
    endfunction

    // ------------------------------------------------------------------------
    // Operand selection.
    // ------------------------------------------------------------------------
    assign a    = (dp.imm_fmt == IMM_Z) ? dp.imm : dp.rs1_data; // zimm for CSRxxI.
    assign b    = dp.use_imm ? dp.imm : dp.rs2_data;
    assign a_s  = a;
    assign b_s  = b;
    assign a_w  = a[31:0];
    assign b_w  = b[31:0];
    assign a_sw = a_w;
    assign b_sw = b_w;

    assign div_zero   = (b == '0);
    assign div_zero_w = (b_w == '0);
    assign ovf   = (a == {1'b1, {(XLEN-1){1'b0}}}) && (&b);
    assign ovf_w = (a_w == 32'h8000_0000) && (&b_w);

    // ------------------------------------------------------------------------
    // Result select.
    // ------------------------------------------------------------------------
    always_comb begin
        case (dp.alu_ctrl)
            ALU_ADD:   res = a + b;
            ALU_SUB:   res = a - b;
            ALU_AND:   res = a & b;
            ALU_OR:    res = a | b;
            ALU_XOR:   res = a ^ b;
            ALU_SLL:   res = a << b[SHW-1:0];
            ALU_SLT:   res = {{(XLEN-1){1'b0}}, (a_s < b_s)};
            ALU_SLTU:  res = {{(XLEN-1){1'b0}}, (a < b)};
            ALU_SRL:   res = a >> b[SHW-1:0];
            ALU_SRA:   res = a_s >>> b[SHW-1:0];
            ALU_ADDW,
            ALU_ADDIW: res = sext_w(a_w + b_w);
            ALU_SUBW:  res = sext_w(a_w - b_w);
            ALU_SLLW:  res = sext_w(a_w << b_w[4:0]);
            ALU_SRLW:  res = sext_w(a_w >> b_w[4:0]);
            ALU_SRAW:  res = sext_w(a_sw >>> b_w[4:0]);
            ALU_CSRRW: res = a;
            ALU_CSRRS: res = dp.csr_data | a;
            ALU_CSRRC: res = dp.csr_data & ~a;
            ALU_MUL:   res = a * b;
            ALU_MULW:  res = sext_w(a_w * b_w);
            ALU_DIVU:  res = div_zero ? '1 : a / b;
            ALU_REMU:  res = div_zero ? a : a % b;
            ALU_REM:   res = div_zero ? a : (ovf ? '0 : a_s % b_s);
            ALU_DIVUW: res = div_zero_w ? '1 : sext_w(a_w / b_w);
            ALU_REMUW: res = div_zero_w ? sext_w(a_w) : sext_w(a_w % b_w);
            ALU_DIVW:  res = div_zero_w ? '1 : (ovf_w ? sext_w(a_w) : sext_w(a_sw / b_sw));
            ALU_REMW:  res = div_zero_w ? sext_w(a_w) : (ovf_w ? '0 : sext_w(a_sw % b_sw));
            default:   res = '0;
        endcase
    end

    assign o_result = dp.illegal ? '0 : res; // Illegal items leave a zero result.

endmodule

// File: rtl/exec_unit.sv
// Execute stage top level; accepts an instruction with operands and returns the ALU result.
`timescale 1ns/100ps

module exec_unit #(
    parameter int XLEN = exec_pkg::XLEN_DEFAULT
) (
    input  logic            i_clk,
    input  logic            i_rst_n,

    // Instruction in.
    input  logic            i_valid,
    output logic            o_ready,
    input  logic [31:0]     i_instr,
    input  logic [XLEN-1:0] i_rs1_data,
    input  logic [XLEN-1:0] i_rs2_data,
    input  logic [XLEN-1:0] i_csr_data,

    // Result out.
    output logic            o_valid,
    input  logic            i_ready,
    output logic [XLEN-1:0] o_result,
    output logic            o_illegal
);

    logic [XLEN-1:0] alu_result;

    exec_ctrl_if #(.XLEN(XLEN)) u_ctrl_if ();

    // ------------------------------------------------------------------------
    // Pipeline control and stage registers.
    // ------------------------------------------------------------------------
    exec_control #(.XLEN(XLEN)) u_control (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .o_ready    (o_ready),
        .i_instr    (i_instr),
        .i_rs1_data (i_rs1_data),
        .i_rs2_data (i_rs2_data),
        .i_csr_data (i_csr_data),
        .i_result   (alu_result),
        .i_illegal  (u_ctrl_if.illegal),
        .o_valid    (o_valid),
        .i_ready    (i_ready),
        .o_result   (o_result),
        .o_illegal  (o_illegal),
        .ctrl       (u_ctrl_if.ctrl)
    );

    // Combinational datapath between the two stages.
    alu_decoder u_alu_decoder (
        .dp (u_ctrl_if.dp)
    );

    imm_gen #(.XLEN(XLEN)) u_imm_gen (
        .dp (u_ctrl_if.dp)
    );

    alu #(.XLEN(XLEN)) u_alu (
        .dp       (u_ctrl_if.dp),
        .o_result (alu_result)
    );

endmodule

// File: verification/exec_unit_tb.sv
// Directed testbench for the execute stage; run it as the simulation top with the file list.
`timescale 1ns/100ps

module exec_unit_tb;
    import exec_pkg::*;

    localparam int N_ITEMS = 19 + 6 + 13 + 9 + 5 + 16;  // Items sent by all tests.
    localparam logic [63:0] MIN64 = 64'h8000_0000_0000_0000;

    logic        i_clk = 1'b0;
    logic        i_rst_n;
    logic        i_valid;
    logic        o_ready;
    logic [31:0] i_instr;
    logic [63:0] i_rs1_data;
    logic [63:0] i_rs2_data;
    logic [63:0] i_csr_data;
    logic        o_valid;
    logic        i_ready;
    logic [63:0] o_result;
    logic        o_illegal;
    integer      seed;
    logic [64:0] exp_q[$];   // {illegal, result} per item in flight.

    exec_unit #(.XLEN(64)) DUT (.*);

    always #4 i_clk = ~i_clk;

    initial begin
        #(N_ITEMS * 20 * 8);
        $display("Something failed");
        $fatal(1, "Watchdog expired before all tests completed");
    end

    // Compares one value and stops the run on a mismatch.
    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            $display("Something failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    // ------------------------------------------------------------------------
    // Encoders and the reference model.
    // ------------------------------------------------------------------------
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [6:0] opc);
        return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [6:0] opc);
        return {imm, rs1, f3, 5'd3, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [64:0] ref_model(input logic [31:0] ins, input logic [63:0] r1,
                                              input logic [63:0] r2, input logic [63:0] csr);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [63:0] imm_i;
        logic [63:0] b;
        logic [63:0] a;
        logic [63:0] res;
        logic [31:0] aw;
        logic [31:0] bw;
        logic [31:0] rw;
        logic        ill;
        opc   = ins[6:0];
        f3    = ins[14:12];
        f7    = ins[31:25];
        imm_i = {{52{ins[31]}}, ins[31:20]};
        b     = (opc == OPC_OP || opc == OPC_OP_32) ? r2 : imm_i;
        aw    = r1[31:0];
        bw    = b[31:0];
        ill   = 1'b0;
        res   = '0;
        rw    = '0;
        case (opc)
            OPC_LOAD:   res = r1 + imm_i;
            OPC_STORE:  res = r1 + {{52{ins[31]}}, ins[31:25], ins[11:7]};
            OPC_BRANCH: res = r1 - r2;
            OPC_OP, OPC_OP_IMM:
                if (opc == OPC_OP && f7 == 7'h01) begin
                    case (f3)
                        3'd0: res = r1 * r2;
                        3'd5:
                            if (r2 == 0) res = '1;
                            else         res = r1 / r2;
                        3'd6: if (r2 == 0) res = r1;
                              else if (r1 == MIN64 && &r2) res = '0;
                              else res = $signed(r1) % $signed(r2);
                        3'd7:
                            if (r2 == 0) res = r1;
                            else         res = r1 % r2;
                        default: ill = 1'b1;
                    endcase
                end else begin
                    case (f3)
                        3'd0:
                            if (opc == OPC_OP && f7[5]) res = r1 - b;
                            else                        res = r1 + b;
                        3'd1: res = r1 << b[5:0];
                        3'd2: res = {63'b0, $signed(r1) < $signed(b)};
                        3'd3: res = {63'b0, r1 < b};
                        3'd4: res = r1 ^ b;
                        3'd5:
                            if (f7[5]) res = $signed(r1) >>> b[5:0];
                            else       res = r1 >> b[5:0];
                        3'd6: res = r1 | b;
                        default: res = r1 & b;
                    endcase
                end
            OPC_OP_32, OPC_OP_IMM_32: begin
                if (f3 == 3'd2 || f3 == 3'd3) ill = 1'b1;
                else if (opc == OPC_OP_32 && f7 == 7'h01) begin
                    case (f3)
                        3'd0: rw = aw * bw;
                        3'd4: if (bw == 0) rw = '1;
                              else if (aw == 32'h8000_0000 && &bw) rw = aw;
                              else rw = $signed(aw) / $signed(bw);
                        3'd5:
                            if (bw == 0) rw = '1;
                            else         rw = aw / bw;
                        3'd6: if (bw == 0) rw = aw;
                              else if (aw == 32'h8000_0000 && &bw) rw = '0;
                              else rw = $signed(aw) % $signed(bw);
                        3'd7:
                            if (bw == 0) rw = aw;
                            else         rw = aw % bw;
                        default: ill = 1'b1;
                    endcase
                end else begin
                    case (f3)
                        3'd0:
                            if (opc == OPC_OP_32 && f7[5]) rw = aw - bw;
                            else                           rw = aw + bw;
                        3'd1: rw = aw << bw[4:0];
                        3'd5:
                            if (f7[5]) rw = $signed(aw) >>> bw[4:0];
                            else       rw = aw >> bw[4:0];
                        default: ill = 1'b1;
                    endcase
                end
                res = {{32{rw[31]}}, rw};
            end
            OPC_SYSTEM: begin
                if (f3[2]) a = {59'b0, ins[19:15]};
                else       a = r1;
                case (f3[1:0])
                    2'd1:    res = a;
                    2'd2:    res = csr | a;
                    2'd3:    res = csr & ~a;
                    default: ill = 1'b1;
                endcase
            end
            default: ill = 1'b1;
        endcase
        if (ill) res = '0;
        return {ill, res};
    endfunction

    // ------------------------------------------------------------------------
    // Drivers and receiver.
    // ------------------------------------------------------------------------
    task automatic send_item(input logic [31:0] ins, input logic [63:0] r1,
                             input logic [63:0] r2, input logic [63:0] csr);
        exp_q.push_back(ref_model(ins, r1, r2, csr));
        @(negedge i_clk);
        i_valid    = 1'b1;
        i_instr    = ins;
        i_rs1_data = r1;
        i_rs2_data = r2;
        i_csr_data = csr;
        #1;
        while (!o_ready) begin
            @(negedge i_clk);
            #1;
        end
        @(posedge i_clk);   // Transfer edge.
    endtask

    task automatic idle_input();
        @(negedge i_clk);
        i_valid = 1'b0;
    endtask

    task automatic recv_items(input string name, input int count, input bit rand_ready);
        int          got;
        logic        held_flag;
        logic [63:0] held;
        logic [64:0] exp;
        got       = 0;
        held_flag = 1'b0;
        while (got < count) begin
            @(negedge i_clk);
            if (rand_ready) i_ready = (($random(seed) & 1) != 0);
            else            i_ready = 1'b1;
            #1;
            if (held_flag) begin
                check_value({name, " held valid"}, 64'd1, {63'b0, o_valid});
                check_value({name, " held result"}, held, o_result);
            end
            held_flag = 1'b0;
            if (o_valid && i_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Something failed");
                    $fatal(1, "A result arrived with no item outstanding");
                end
                exp = exp_q.pop_front();
                check_value({name, " result"}, exp[63:0], o_result);
                check_value({name, " illegal"}, {63'b0, exp[64]}, {63'b0, o_illegal});
                got++;
            end else if (o_valid) begin
                held      = o_result;
                held_flag = 1'b1;
            end
        end
    endtask

    task automatic run_one(input string name, input logic [31:0] ins, input logic [63:0] r1,
                           input logic [63:0] r2, input logic [63:0] csr);
        send_item(ins, r1, r2, csr);
        idle_input();
        recv_items(name, 1, 1'b0);
    endtask

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // ------------------------------------------------------------------------
    // Directed tests.
    // ------------------------------------------------------------------------
    task automatic base_integer_ops();
        logic [11:0] imm;
        for (int f3 = 0; f3 < 8; f3++)
            run_one("op", enc_r(7'h00, f3[2:0], OPC_OP), rand64(), rand64(), 64'd0);
        run_one("sub", enc_r(7'h20, 3'd0, OPC_OP), rand64(), rand64(), 64'd0);
        run_one("sra", enc_r(7'h20, 3'd5, OPC_OP), rand64() | MIN64, rand64(), 64'd0);
        for (int f3 = 0; f3 < 8; f3++) begin
            imm = $random(seed);
            if (f3 == 1) imm = {6'b0, imm[5:0]};
            if (f3 == 5) imm = {6'b000000, imm[5:0]};
            run_one("op_imm", enc_i(imm, 5'd1, f3[2:0], OPC_OP_IMM), rand64(), 64'd0, 64'd0);
        end
        imm = $random(seed);
        run_one("srai", enc_i({6'b010000, imm[5:0]}, 5'd1, 3'd5, OPC_OP_IMM),
                rand64() | MIN64, 64'd0, 64'd0);
    endtask

    task automatic word_forms();
        run_one("addw", enc_r(7'h00, 3'd0, OPC_OP_32), 64'h1234_0000_7fff_ffff, 64'd1, 64'd0);
        run_one("subw", enc_r(7'h20, 3'd0, OPC_OP_32), 64'h0000_0001_8000_0000, 64'd1, 64'd0);
        run_one("addiw", enc_i(12'h7ff, 5'd1, 3'd0, OPC_OP_IMM_32),
                64'hffff_0000_7fff_ff00, 64'd0, 64'd0);
        run_one("sllw", enc_r(7'h00, 3'd1, OPC_OP_32), 64'h0000_0000_0000_0003, 64'd31, 64'd0);
        run_one("srlw", enc_r(7'h00, 3'd5, OPC_OP_32), 64'h5555_5555_8000_0000, 64'd4, 64'd0);
        run_one("sraw", enc_r(7'h20, 3'd5, OPC_OP_32), 64'h0000_0000_8000_0010, 64'd4, 64'd0);
    endtask

    task automatic m_extension();
        run_one("mul", enc_r(7'h01, 3'd0, OPC_OP), rand64(), rand64(), 64'd0);
        run_one("mulw", enc_r(7'h01, 3'd0, OPC_OP_32), rand64(), rand64(), 64'd0);
        run_one("divu", enc_r(7'h01, 3'd5, OPC_OP), rand64(), 64'd12345, 64'd0);
        run_one("divu zero", enc_r(7'h01, 3'd5, OPC_OP), rand64(), 64'd0, 64'd0);
        run_one("divuw", enc_r(7'h01, 3'd5, OPC_OP_32), 64'h0000_0000_f000_0000, 64'd3, 64'd0);
        run_one("divw", enc_r(7'h01, 3'd4, OPC_OP_32), 64'h0000_0000_ffff_ff9c, 64'd7, 64'd0);
        run_one("divw zero", enc_r(7'h01, 3'd4, OPC_OP_32), 64'd77, 64'd0, 64'd0);
        run_one("divw ovf", enc_r(7'h01, 3'd4, OPC_OP_32), 64'h8000_0000, 64'hffff_ffff, 64'd0);
        run_one("rem", enc_r(7'h01, 3'd6, OPC_OP), 64'd1000, 64'd7, 64'd0);
        run_one("rem ovf", enc_r(7'h01, 3'd6, OPC_OP), MIN64, '1, 64'd0);
        run_one("remu zero", enc_r(7'h01, 3'd7, OPC_OP), rand64(), 64'd0, 64'd0);
        run_one("remw", enc_r(7'h01, 3'd6, OPC_OP_32), 64'h0000_0000_ffff_ff9c, 64'd7, 64'd0);
        run_one("remuw", enc_r(7'h01, 3'd7, OPC_OP_32), 64'h0000_0000_f000_0001, 64'd0, 64'd0);
    endtask

    task automatic csr_and_memory();
        logic [63:0] csr;
        csr = rand64();
        for (int f3 = 1; f3 < 8; f3++)
            if (f3 != 4)
                run_one("csr", enc_i(12'h300, 5'h15, f3[2:0], OPC_SYSTEM), rand64(), 64'd0, csr);
        run_one("load", enc_i(12'hf80, 5'd1, 3'd3, OPC_LOAD), rand64(), 64'd0, 64'd0);
        run_one("store", enc_s(12'h81c, 3'd3), rand64(), rand64(), 64'd0);
        run_one("branch", enc_r(7'h00, 3'd0, OPC_BRANCH), rand64(), rand64(), 64'd0);
    endtask

    task automatic illegal_detection();
        run_one("ill w010", enc_r(7'h00, 3'd2, OPC_OP_32), rand64(), rand64(), 64'd0);
        run_one("ill w011", enc_r(7'h00, 3'd3, OPC_OP_32), rand64(), rand64(), 64'd0);
        run_one("ill ecall", enc_i(12'h000, 5'd0, 3'd0, OPC_SYSTEM), rand64(), 64'd0, 64'd0);
        run_one("ill csr100", enc_i(12'h300, 5'd1, 3'd4, OPC_SYSTEM), rand64(), 64'd0, 64'd0);
        run_one("ill lui", {20'habcde, 5'd3, 7'b0110111}, rand64(), 64'd0, 64'd0);
    endtask

    task automatic backpressure_stream();
        fork
            begin
                for (int i = 0; i < 16; i++) begin
                    case ($random(seed) & 3)
                        0: send_item(enc_r(7'h00, 3'd0, OPC_OP), rand64(), rand64(), 64'd0);
                        1: send_item(enc_r(7'h20, 3'd0, OPC_OP), rand64(), rand64(), 64'd0);
                        2: send_item(enc_r(7'h00, 3'd4, OPC_OP), rand64(), rand64(), 64'd0);
                        default: send_item(enc_r(7'h01, 3'd0, OPC_OP_32), rand64(), rand64(),
                                           64'd0);
                    endcase
                end
                idle_input();
            end
            recv_items("stream", 16, 1'b1);
        join
        // The pipeline must drain to empty with no extra result.
        repeat (3) begin
            @(negedge i_clk);
            i_ready = 1'b1;
            #1;
            check_value("stream extra", 64'd0, {63'b0, o_valid});
        end
    endtask

    initial begin
        seed       = 67648;
        i_rst_n    = 1'b0;
        i_valid    = 1'b0;
        i_ready    = 1'b1;
        i_instr    = '0;
        i_rs1_data = '0;
        i_rs2_data = '0;
        i_csr_data = '0;
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        #1;
        check_value("reset ready", 64'd1, {63'b0, o_ready});
        check_value("reset valid", 64'd0, {63'b0, o_valid});
        base_integer_ops();
        word_forms();
        m_extension();
        csr_and_memory();
        illegal_detection();
        backpressure_stream();
        $display("Everything OK");
        $finish;
    end

endmodule

// File: all.f
rtl/exec_pkg.sv
rtl/exec_ctrl_if.sv
rtl/exec_control.sv
rtl/alu_decoder.sv
rtl/imm_gen.sv
rtl/alu.sv
rtl/exec_unit.sv
verification/exec_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= exec_unit_tb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
